/* sources.f */
+incdir+include
hdl/rename_pkg.sv
hdl/rename_if.sv
hdl/rename_map.sv
hdl/free_list.sv
hdl/reorder_buffer.sv
hdl/retire_map.sv
hdl/rename_core.sv
verif/rename_core_tb.sv

/* verif/rename_core_tb.sv */
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_core_tb;
    import rename_pkg::*;

    localparam int ROB_DEPTH     = `RENAME_ROB_DEPTH;
    localparam int ARCH_REGS     = `RENAME_ARCH_REGS;
    localparam int PHYS_REGS     = `RENAME_PHYS_REGS;
    localparam int FREE_SLOTS    = PHYS_REGS - ARCH_REGS;
    localparam int RESET_CYCLES  = 5;
    localparam int MAP_CYCLES    = ARCH_REGS;
    localparam int RANDOM_CYCLES = 2000;
    localparam int TEST_CYCLES   = RESET_CYCLES + MAP_CYCLES + RANDOM_CYCLES;
    localparam int CYCLE_LIMIT   = ((TEST_CYCLES + 99) / 100) * 100 + 400;

    typedef struct packed {
        rob_idx_t  idx;
        logic      writes;
        arch_reg_t rd;
        phys_reg_t pd;
        logic      done;
    } rob_entry_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      dispatch_valid_i;
    logic      dispatch_we_i;
    arch_reg_t rd_i;
    arch_reg_t rs1_i;
    arch_reg_t rs2_i;
    logic      dispatch_ready_o;
    phys_reg_t ps1_o;
    phys_reg_t ps2_o;
    logic      ps1_ready_o;
    logic      ps2_ready_o;
    phys_reg_t pd_o;
    rob_idx_t  rob_idx_o;
    logic      cdb_valid_i;
    rob_idx_t  cdb_rob_idx_i;
    logic      flush_i;
    logic      retire_valid_o;
    logic      retire_writes_o;
    arch_reg_t retire_rd_o;
    phys_reg_t retire_pd_o;

    // reference model
    phys_reg_t  m_rat   [ARCH_REGS];
    phys_reg_t  m_rrat  [ARCH_REGS];
    logic       m_ready [PHYS_REGS];
    phys_reg_t  fl_q    [$];  // registers in the order they entered the free list
    int         fl_head;
    rob_entry_t rob_q   [$];  // oldest entry first
    int         rob_tail;

    int cycle_count = 0;
    int mismatch_count = 0;
    int other_count = 0;
    int n_fire = 0;
    int n_retire = 0;
    int n_flush = 0;
    int n_full = 0;

    rename_core dut0 (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("timeout: the run hung and did not finish within %0d cycles", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("CHECK FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
        mismatch_count++;
    endtask

    task automatic report_problem(string msg);
        $display("error at %0t: %s", $time, msg);
        other_count++;
    endtask

    function automatic int free_count();
        return fl_q.size() - fl_head;
    endfunction

    // half the picks land in x0..x7 so dependencies show up often
    function automatic arch_reg_t pick_reg();
        if ($urandom_range(1) == 0) begin
            return arch_reg_t'($urandom_range(7));
        end
        return arch_reg_t'($urandom_range(ARCH_REGS - 1));
    endfunction

    task automatic model_reset();
        for (int i = 0; i < ARCH_REGS; i++) begin
            m_rat[i]  = phys_reg_t'(i);
            m_rrat[i] = phys_reg_t'(i);
        end
        foreach (m_ready[i]) begin
            m_ready[i] = 1'b1;
        end
        fl_q.delete();
        for (int i = 0; i < FREE_SLOTS; i++) begin
            fl_q.push_back(phys_reg_t'(ARCH_REGS + i));
        end
        fl_head  = 0;
        rob_q.delete();
        rob_tail = 0;
    endtask

    task automatic drive_random();
        int pending [$];

        dispatch_valid_i <= ($urandom_range(99) < 70);
        dispatch_we_i    <= $urandom_range(1);
        rd_i             <= ($urandom_range(3) == 0) ? arch_reg_t'(0) : pick_reg();
        rs1_i            <= pick_reg();
        rs2_i            <= pick_reg();
        flush_i          <= ($urandom_range(149) == 0);
        foreach (rob_q[i]) begin
            if (!rob_q[i].done) begin
                pending.push_back(rob_q[i].idx);
            end
        end
        if (pending.size() > 0 && $urandom_range(99) < 60) begin
            cdb_valid_i   <= 1'b1;
            cdb_rob_idx_i <= rob_idx_t'(pending[$urandom_range(pending.size() - 1)]);
        end else begin
            cdb_valid_i   <= 1'b0;
        end
    endtask

    // compares this cycle's outputs and then advances the model across the next edge
    task automatic check_and_step();
        logic       needs_pd;
        logic       exp_ready;
        logic       exp_fire;
        logic       exp_rv;
        logic       exp_rw;
        phys_reg_t  exp_ps1;
        phys_reg_t  exp_ps2;
        phys_reg_t  exp_pd;
        rob_entry_t head;
        rob_entry_t ent;
        int         in_use;

        needs_pd  = dispatch_we_i && (rd_i != '0);
        exp_ready = !flush_i && (rob_q.size() < ROB_DEPTH) && !(needs_pd && free_count() == 0);
        exp_fire  = dispatch_valid_i && exp_ready;
        exp_ps1   = m_rat[rs1_i];
        exp_ps2   = m_rat[rs2_i];
        exp_pd    = (exp_fire && needs_pd) ? fl_q[fl_head] : '0;
        exp_rv    = !flush_i && (rob_q.size() > 0) && rob_q[0].done;
        exp_rw    = exp_rv && rob_q[0].writes;

        if (dispatch_ready_o !== exp_ready)
            report_mismatch("dispatch_ready_o", exp_ready, dispatch_ready_o);
        if (ps1_o !== exp_ps1) report_mismatch("ps1_o", exp_ps1, ps1_o);
        if (ps2_o !== exp_ps2) report_mismatch("ps2_o", exp_ps2, ps2_o);
        if (ps1_ready_o !== m_ready[exp_ps1])
            report_mismatch("ps1_ready_o", m_ready[exp_ps1], ps1_ready_o);
        if (ps2_ready_o !== m_ready[exp_ps2])
            report_mismatch("ps2_ready_o", m_ready[exp_ps2], ps2_ready_o);
        if (pd_o !== exp_pd) report_mismatch("pd_o", exp_pd, pd_o);
        if (rob_idx_o !== rob_idx_t'(rob_tail)) report_mismatch("rob_idx_o", rob_tail, rob_idx_o);
        if (retire_valid_o !== exp_rv) report_mismatch("retire_valid_o", exp_rv, retire_valid_o);
        if (retire_writes_o !== exp_rw)
            report_mismatch("retire_writes_o", exp_rw, retire_writes_o);
        if (exp_rw) begin
            if (retire_rd_o !== rob_q[0].rd)
                report_mismatch("retire_rd_o", rob_q[0].rd, retire_rd_o);
            if (retire_pd_o !== rob_q[0].pd)
                report_mismatch("retire_pd_o", rob_q[0].pd, retire_pd_o);
        end

        // a fresh destination must not be held by the committed map or an in-flight entry
        if (exp_fire && needs_pd) begin
            in_use = 0;
            foreach (m_rrat[i]) begin
                if (m_rrat[i] == pd_o) in_use++;
            end
            foreach (rob_q[i]) begin
                if (rob_q[i].writes && rob_q[i].pd == pd_o) in_use++;
            end
            if (in_use != 0) begin
                report_problem("pd_o hands out a physical register that is still in use");
            end
        end

        if (rob_q.size() == ROB_DEPTH) n_full++;
        if (flush_i) begin
            n_flush++;
            m_rat = m_rrat;
            foreach (m_ready[i]) begin
                m_ready[i] = 1'b1;
            end
            rob_q.delete();
            fl_head = fl_q.size() - FREE_SLOTS;  // uncommitted registers are free again
        end else begin
            if (cdb_valid_i) begin
                foreach (rob_q[i]) begin
                    if (rob_q[i].idx == cdb_rob_idx_i) begin
                        if (rob_q[i].writes) m_ready[rob_q[i].pd] = 1'b1;
                        rob_q[i].done = 1'b1;
                    end
                end
            end
            if (exp_rv) begin
                head = rob_q.pop_front();
                n_retire++;
                if (head.writes) begin
                    fl_q.push_back(m_rrat[head.rd]);  // superseded mapping
                    m_rrat[head.rd] = head.pd;
                end
            end
            if (exp_fire) begin
                ent = '0;
                ent.idx    = rob_idx_t'(rob_tail);
                ent.writes = needs_pd;
                ent.rd     = rd_i;
                if (needs_pd) begin
                    ent.pd = fl_q[fl_head];
                    fl_head++;
                    m_rat[rd_i]     = ent.pd;
                    m_ready[ent.pd] = 1'b0;
                end
                rob_q.push_back(ent);
                rob_tail = (rob_tail + 1) % ROB_DEPTH;
                n_fire++;
            end
        end
        while (fl_head > 0 && fl_q.size() > FREE_SLOTS) begin
            void'(fl_q.pop_front());
            fl_head--;
        end
    endtask

    initial begin
        rst              = 1'b1;
        dispatch_valid_i = 1'b0;
        dispatch_we_i    = 1'b0;
        rd_i             = '0;
        rs1_i            = '0;
        rs2_i            = '0;
        cdb_valid_i      = 1'b0;
        cdb_rob_idx_i    = '0;
        flush_i          = 1'b0;
        void'($urandom(63));
        model_reset();

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // identity map and all sources ready straight out of reset
        for (int i = 0; i < MAP_CYCLES; i++) begin
            @(posedge clk);
            rs1_i <= arch_reg_t'(i);
            rs2_i <= arch_reg_t'(MAP_CYCLES - 1 - i);
            @(negedge clk);
            if (ps1_o !== phys_reg_t'(i)) report_mismatch("ps1_o", i, ps1_o);
            if (ps1_ready_o !== 1'b1) report_mismatch("ps1_ready_o", 1, ps1_ready_o);
            if (ps2_ready_o !== 1'b1) report_mismatch("ps2_ready_o", 1, ps2_ready_o);
            if (dispatch_ready_o !== 1'b1) report_mismatch("dispatch_ready_o", 1, dispatch_ready_o);
            if (retire_valid_o !== 1'b0) report_mismatch("retire_valid_o", 0, retire_valid_o);
            check_and_step();
        end

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            @(posedge clk);
            drive_random();
            @(negedge clk);
            check_and_step();
        end

        $display("errors: %0d mismatches, %0d other; %0d dispatched, %0d retired, %0d flushes, %0d rob full",
                 mismatch_count, other_count, n_fire, n_retire, n_flush, n_full);
        if (mismatch_count + other_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : rename_core_tb

/* hdl/rename_core.sv */
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_core (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 dispatch_valid_i,
    input  logic                 dispatch_we_i,
    input  rename_pkg::arch_reg_t rd_i,
    input  rename_pkg::arch_reg_t rs1_i,
    input  rename_pkg::arch_reg_t rs2_i,
    output logic                 dispatch_ready_o,
    output rename_pkg::phys_reg_t ps1_o,
    output rename_pkg::phys_reg_t ps2_o,
    output logic                 ps1_ready_o,
    output logic                 ps2_ready_o,
    output rename_pkg::phys_reg_t pd_o,
    output rename_pkg::rob_idx_t  rob_idx_o,

    input  logic                 cdb_valid_i,
    input  rename_pkg::rob_idx_t  cdb_rob_idx_i,
    input  logic                 flush_i,

    output logic                 retire_valid_o,
    output logic                 retire_writes_o,
    output rename_pkg::arch_reg_t retire_rd_o,
    output rename_pkg::phys_reg_t retire_pd_o
);
    import rename_pkg::*;

    logic      wake_valid;
    phys_reg_t wake_pd;
    phys_reg_t committed_map [`RENAME_ARCH_REGS];

    alloc_if  alloc_bus ();
    retire_if retire_bus ();

    rename_map rename_map_i (
        .clk              (clk),
        .rst              (rst),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_we_i    (dispatch_we_i),
        .rd_i             (rd_i),
        .rs1_i            (rs1_i),
        .rs2_i            (rs2_i),
        .flush_i          (flush_i),
        .ps1_o            (ps1_o),
        .ps2_o            (ps2_o),
        .ps1_ready_o      (ps1_ready_o),
        .ps2_ready_o      (ps2_ready_o),
        .pd_o             (pd_o),
        .dispatch_ready_o (dispatch_ready_o),
        .alloc            (alloc_bus.manager),
        .wake_valid_i     (wake_valid),
        .wake_pd_i        (wake_pd),
        .committed_map_i  (committed_map)
    );

    free_list free_list_i (
        .clk     (clk),
        .rst     (rst),
        .flush_i (flush_i),
        .alloc   (alloc_bus.member),
        .retire  (retire_bus.member)
    );

    reorder_buffer rob_i (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .alloc         (alloc_bus.member),
        .rob_idx_o     (rob_idx_o),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_rob_idx_i (cdb_rob_idx_i),
        .wake_valid_o  (wake_valid),
        .wake_pd_o     (wake_pd),
        .retire        (retire_bus.manager)
    );

    retire_map retire_map_i (
        .clk             (clk),
        .rst             (rst),
        .retire          (retire_bus.member),
        .committed_map_o (committed_map)
    );

    assign retire_valid_o  = retire_bus.valid;
    assign retire_writes_o = retire_bus.writes;
    assign retire_rd_o     = retire_bus.rd;
    assign retire_pd_o     = retire_bus.pd;

endmodule : rename_core

/* hdl/retire_map.sv */
`timescale 1ns/1ps
`include "rename_config.svh"

module retire_map (
    input  logic                 clk,
    input  logic                 rst,
    retire_if.member             retire,
    output rename_pkg::phys_reg_t committed_map_o [`RENAME_ARCH_REGS]
);
    import rename_pkg::*;

    phys_reg_t rrat_q [`RENAME_ARCH_REGS];

    logic commit;

    assign commit = retire.valid && retire.writes;

    // previous committed owner of rd goes back to the free list
    assign retire.old_pd = rrat_q[retire.rd];

    assign committed_map_o = rrat_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
                rrat_q[i] <= phys_reg_t'(i);
            end
        end else if (commit) begin
            rrat_q[retire.rd] <= retire.pd;
        end
    end

endmodule : retire_map

/* hdl/reorder_buffer.sv */
`timescale 1ns/1ps
`include "rename_config.svh"

module reorder_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush_i,

    alloc_if.member              alloc,
    output rename_pkg::rob_idx_t  rob_idx_o,

    input  logic                 cdb_valid_i,
    input  rename_pkg::rob_idx_t  cdb_rob_idx_i,

    output logic                 wake_valid_o,
    output rename_pkg::phys_reg_t wake_pd_o,

    retire_if.manager            retire
);
    import rename_pkg::*;

    localparam int DEPTH = `RENAME_ROB_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    // entry payload
    logic      writes_q [DEPTH];
    arch_reg_t rd_q     [DEPTH];
    phys_reg_t pd_q     [DEPTH];

    logic [DEPTH-1:0] done_q;

    rob_ptr_t head_q;
    rob_ptr_t tail_q;

    rob_idx_t head_idx;
    rob_idx_t tail_idx;

    logic rob_empty;
    logic rob_full;
    logic retire_valid;
    logic complete;

    assign head_idx = head_q[AW-1:0];
    assign tail_idx = tail_q[AW-1:0];

    assign rob_empty = (head_q == tail_q);
    assign rob_full  = (head_idx == tail_idx) && (head_q[AW] != tail_q[AW]);

    assign alloc.full = rob_full;
    assign rob_idx_o  = tail_idx;

    // completions are dropped while flushing
    assign complete = cdb_valid_i && !flush_i;

    // wakeup for the destination of the completing entry
    assign wake_valid_o = complete && writes_q[cdb_rob_idx_i];
    assign wake_pd_o    = pd_q[cdb_rob_idx_i];

    assign retire_valid = !rob_empty && done_q[head_idx] && !flush_i;

    assign retire.valid  = retire_valid;
    assign retire.writes = retire_valid && writes_q[head_idx];
    assign retire.rd     = rd_q[head_idx];
    assign retire.pd     = pd_q[head_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            done_q <= '0;
        end else if (flush_i) begin
            head_q <= tail_q;  // drop every speculative entry
            done_q <= '0;
        end else begin
            if (complete) begin
                done_q[cdb_rob_idx_i] <= 1'b1;
            end
            if (alloc.fire) begin
                done_q[tail_idx] <= 1'b0;
                tail_q           <= tail_q + 1'b1;
            end
            if (retire_valid) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.fire) begin
            writes_q[tail_idx] <= alloc.alloc;
            rd_q[tail_idx]     <= alloc.rd;
            pd_q[tail_idx]     <= alloc.pd;  // only meaningful with writes set
        end
    end

endmodule : reorder_buffer

/* hdl/free_list.sv */
`timescale 1ns/1ps
`include "rename_config.svh"

module free_list (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush_i,
    alloc_if.member   alloc,
    retire_if.member  retire
);
    import rename_pkg::*;

    localparam int SLOTS = `RENAME_PHYS_REGS - `RENAME_ARCH_REGS;
    localparam int AW    = $clog2(SLOTS);

    phys_reg_t slot_q [SLOTS];
    fl_ptr_t   head_q;
    fl_ptr_t   tail_q;

    logic push;
    logic pop;

    assign pop  = alloc.alloc;
    assign push = retire.valid && retire.writes;

    assign alloc.pd    = slot_q[head_q[AW-1:0]];
    assign alloc.empty = (head_q == tail_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= {1'b1, {AW{1'b0}}};  // wrap bits differ when full
        end else if (flush_i) begin
            // every slot behind the tail is uncommitted again
            head_q <= {~tail_q[AW], tail_q[AW-1:0]};
        end else begin
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            if (push) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    // initial contents are registers above the architectural range
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SLOTS; i++) begin
                slot_q[i] <= phys_reg_t'(`RENAME_ARCH_REGS + i);
            end
        end else if (push && !flush_i) begin
            slot_q[tail_q[AW-1:0]] <= retire.old_pd;
        end
    end

endmodule : free_list

/* hdl/rename_map.sv */
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_map (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 dispatch_valid_i,
    input  logic                 dispatch_we_i,
    input  rename_pkg::arch_reg_t rd_i,
    input  rename_pkg::arch_reg_t rs1_i,
    input  rename_pkg::arch_reg_t rs2_i,
    input  logic                 flush_i,

    output rename_pkg::phys_reg_t ps1_o,
    output rename_pkg::phys_reg_t ps2_o,
    output logic                 ps1_ready_o,
    output logic                 ps2_ready_o,
    output rename_pkg::phys_reg_t pd_o,
    output logic                 dispatch_ready_o,

    alloc_if.manager             alloc,

    input  logic                 wake_valid_i,
    input  rename_pkg::phys_reg_t wake_pd_i,
    input  rename_pkg::phys_reg_t committed_map_i [`RENAME_ARCH_REGS]
);
    import rename_pkg::*;

    phys_reg_t                     rat_q [`RENAME_ARCH_REGS];
    logic [`RENAME_PHYS_REGS-1:0]  ready_q;

    logic needs_pd;
    logic fire;
    logic do_alloc;

    // x0 never takes a new register
    assign needs_pd = dispatch_we_i && (rd_i != '0);

    always_comb begin
        dispatch_ready_o = 1'b1;
        if (flush_i) begin
            dispatch_ready_o = 1'b0;
        end else if (alloc.full) begin
            dispatch_ready_o = 1'b0;
        end else if (needs_pd && alloc.empty) begin
            dispatch_ready_o = 1'b0;
        end
    end

    assign fire     = dispatch_valid_i && dispatch_ready_o;
    assign do_alloc = fire && needs_pd;

    assign alloc.fire  = fire;
    assign alloc.alloc = do_alloc;
    assign alloc.rd    = rd_i;

    // lookups use the table as it stood at the start of the cycle
    assign ps1_o       = rat_q[rs1_i];
    assign ps2_o       = rat_q[rs2_i];
    assign ps1_ready_o = ready_q[ps1_o];
    assign ps2_ready_o = ready_q[ps2_o];
    assign pd_o        = do_alloc ? alloc.pd : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
                rat_q[i] <= phys_reg_t'(i);  // identity map
            end
            ready_q <= '1;
        end else if (flush_i) begin
            rat_q   <= committed_map_i;
            ready_q <= '1;  // committed values are all written
        end else begin
            if (wake_valid_i) begin
                ready_q[wake_pd_i] <= 1'b1;
            end
            if (do_alloc) begin
                rat_q[rd_i]       <= alloc.pd;
                ready_q[alloc.pd] <= 1'b0;
            end
        end
    end

endmodule : rename_map

/* hdl/rename_if.sv */
`timescale 1ns/1ps

// accepted dispatch, seen by the free list and the reorder buffer
interface alloc_if;
    import rename_pkg::*;

    logic      fire;   // instruction accepted this cycle
    logic      alloc;  // accepted and needs a new destination
    arch_reg_t rd;
    phys_reg_t pd;     // head of the free list
    logic      full;   // rob has no free slot
    logic      empty;  // free list has no register

    modport manager (
        output fire,
        output alloc,
        output rd,
        input  pd,
        input  full,
        input  empty
    );

    modport member (
        input  fire,
        input  alloc,
        input  rd,
        output pd,
        output full,
        output empty
    );
endinterface : alloc_if

// in-order retirement from the rob head
interface retire_if;
    import rename_pkg::*;

    logic      valid;
    logic      writes;  // retiring entry owns a destination
    arch_reg_t rd;
    phys_reg_t pd;
    phys_reg_t old_pd;  // mapping superseded by this retirement

    modport manager (
        output valid,
        output writes,
        output rd,
        output pd
    );

    modport member (
        input  valid,
        input  writes,
        input  rd,
        input  pd,
        output old_pd
    );
endinterface : retire_if

/* hdl/rename_pkg.sv */
`include "rename_config.svh"

package rename_pkg;

    // architectural register number x0..x31
    typedef logic [$clog2(`RENAME_ARCH_REGS)-1:0] arch_reg_t;

    // physical register number
    typedef logic [$clog2(`RENAME_PHYS_REGS)-1:0] phys_reg_t;

    // reorder buffer slot
    typedef logic [$clog2(`RENAME_ROB_DEPTH)-1:0] rob_idx_t;

    // reorder buffer pointer with slot and wrap bit
    typedef logic [$clog2(`RENAME_ROB_DEPTH):0] rob_ptr_t;

    // free list pointer with slot and wrap bit
    // the free list holds every register not needed by the committed map
    typedef logic [$clog2(`RENAME_PHYS_REGS - `RENAME_ARCH_REGS):0] fl_ptr_t;

endpackage : rename_pkg

/* include/rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural register file of RV32I
`define RENAME_ARCH_REGS 32

// physical register file behind the alias table
`define RENAME_PHYS_REGS 64

// reorder buffer entries as a power of two so the pointers wrap cleanly
`define RENAME_ROB_DEPTH 16

`endif
